// File: bus_node_pkg.sv
package bus_node_pkg;

    // Packet layout
    localparam int pkt_width  = 16;
    localparam int addr_width = 8;   // Destination field at the top of a packet

    // Time-division arbitration
    localparam int num_nodes  = 4;
    localparam int slot_width = 2;

    // Frame bit counter, one spare bit over the packet length
    localparam int bit_cnt_width = 5;

    typedef logic [pkt_width-1:0]  pkt_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [slot_width-1:0] slot_t;

    // Accepted by every node
    localparam addr_t broadcast_addr = '1;

    // Write side
    typedef enum logic [1:0] {
        tx_idle = 2'b00,   // Waiting for grant with data pending
        tx_load = 2'b01,   // First bit of the loaded word on the bus
        tx_send = 2'b10    // Remaining bits
    } tx_state_t;

    // Read side
    typedef enum logic [1:0] {
        rx_idle  = 2'b00,  // Bus quiet
        rx_shift = 2'b01,  // Collecting frame bits
        rx_check = 2'b10   // Address compare and push
    } rx_state_t;

endpackage

// File: shift_reg.sv
`timescale 1ns/1ps

module shift_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  logic               shift,
    input  bus_node_pkg::pkt_t load_data,
    input  logic               serial_in,
    output bus_node_pkg::pkt_t data,
    output logic               serial_out
);

    // Parallel load wins over shift
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data <= '0;
        end else if (load) begin
            data <= load_data;
        end else if (shift) begin
            // MSB leaves first, new bit enters at the bottom
            data <= {data[bus_node_pkg::pkt_width-2:0], serial_in};
        end
    end

    assign serial_out = data[bus_node_pkg::pkt_width-1];  // Current MSB

endmodule

// File: slot_arbiter.sv
`timescale 1ns/1ps

module slot_arbiter #(
    parameter bus_node_pkg::addr_t node_id = 8'd2
) (
    input  logic clk,
    input  logic rst,
    input  logic bsy_in,
    input  logic tx_busy,
    output logic grant
);

    bus_node_pkg::slot_t slot;
    logic                bus_idle;
    logic                last_slot;

    assign bus_idle  = !bsy_in && !tx_busy;  // Nobody on the bus, own frame included
    assign last_slot = (int'(slot) == bus_node_pkg::num_nodes - 1);

    // Slot only moves on quiet cycles, so a frame holds the turn in place
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot <= '0;
        end else if (bus_idle) begin
            if (last_slot) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Our turn when the slot matches the low id bits
    assign grant = bus_idle && (slot == node_id[bus_node_pkg::slot_width-1:0]);

endmodule

// File: tx_fsm.sv
`timescale 1ns/1ps

module tx_fsm (
    input  logic clk,
    input  logic rst,
    input  logic grant,
    input  logic pndng,
    output logic pop,
    output logic load,
    output logic shift,
    output logic tx_busy
);

    bus_node_pkg::tx_state_t                state;
    bus_node_pkg::tx_state_t                next_state;
    logic [bus_node_pkg::bit_cnt_width-1:0] bit_cnt;
    logic                                   last_bit;

    assign last_bit = (int'(bit_cnt) == bus_node_pkg::pkt_width - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= bus_node_pkg::tx_idle;
        end else begin
            state <= next_state;
        end
    end

    // Counts bits already placed on the bus
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_cnt <= '0;
        end else if (tx_busy) begin
            bit_cnt <= bit_cnt + 1'b1;
        end else begin
            bit_cnt <= '0;
        end
    end

    always_comb begin
        next_state = state;
        pop        = 1'b0;
        load       = 1'b0;
        shift      = 1'b0;
        tx_busy    = 1'b0;
        case (state)
            bus_node_pkg::tx_idle: begin
                // Pop and load on the same edge, head word is sampled there
                if (grant && pndng) begin
                    pop        = 1'b1;
                    load       = 1'b1;
                    next_state = bus_node_pkg::tx_load;
                end
            end
            bus_node_pkg::tx_load: begin
                tx_busy    = 1'b1;   // MSB goes out here
                shift      = 1'b1;
                next_state = bus_node_pkg::tx_send;
            end
            bus_node_pkg::tx_send: begin
                tx_busy = 1'b1;
                shift   = 1'b1;
                if (last_bit) begin
                    next_state = bus_node_pkg::tx_idle;
                end
            end
            default: begin
                next_state = bus_node_pkg::tx_idle;
            end
        endcase
    end

endmodule

// File: rx_fsm.sv
`timescale 1ns/1ps

module rx_fsm #(
    parameter bus_node_pkg::addr_t node_id = 8'd2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               bsy_in,
    input  bus_node_pkg::pkt_t rx_data,
    output logic               shift,
    output logic               push
);

    bus_node_pkg::rx_state_t                state;
    bus_node_pkg::rx_state_t                next_state;
    logic [bus_node_pkg::bit_cnt_width-1:0] bit_cnt;
    logic                                   last_bit;
    bus_node_pkg::addr_t                    dest;
    logic                                   addr_hit;

    // Destination sits in the top byte
    assign dest = rx_data[bus_node_pkg::pkt_width-1 -: bus_node_pkg::addr_width];

    assign addr_hit = (dest == node_id) || (dest == bus_node_pkg::broadcast_addr);
    assign last_bit = (int'(bit_cnt) == bus_node_pkg::pkt_width - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= bus_node_pkg::rx_idle;
        end else begin
            state <= next_state;
        end
    end

    // Bits taken so far in the current frame
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_cnt <= '0;
        end else if (shift) begin
            bit_cnt <= bit_cnt + 1'b1;
        end else begin
            bit_cnt <= '0;
        end
    end

    always_comb begin
        next_state = state;
        shift      = 1'b0;
        push       = 1'b0;
        case (state)
            bus_node_pkg::rx_idle: begin
                if (bsy_in) begin
                    shift      = 1'b1;   // First bit of a frame
                    next_state = bus_node_pkg::rx_shift;
                end
            end
            bus_node_pkg::rx_shift: begin
                if (bsy_in) begin
                    shift = 1'b1;
                    if (last_bit) begin
                        next_state = bus_node_pkg::rx_check;
                    end
                end else begin
                    // Busy dropped early, frame is dropped
                    next_state = bus_node_pkg::rx_idle;
                end
            end
            bus_node_pkg::rx_check: begin
                push       = addr_hit;   // Whole word is in the register now
                next_state = bus_node_pkg::rx_idle;
            end
            default: begin
                next_state = bus_node_pkg::rx_idle;
            end
        endcase
    end

endmodule

// File: bus_node.sv
`timescale 1ns/1ps

module bus_node #(
    parameter bus_node_pkg::addr_t node_id = 8'd2
) (
    input  logic               clk,
    input  logic               rst,
    // FIFO side
    input  logic               pndng,
    input  bus_node_pkg::pkt_t d_pop,
    output logic               pop,
    output logic               push,
    output bus_node_pkg::pkt_t d_push,
    // Shared bus
    input  logic               bus_in,
    input  logic               bsy_in,
    output logic               bus_out,
    output logic               bus_oe,
    output logic               bsy_out
);

    logic grant;
    logic tx_busy;
    logic tx_load;
    logic tx_shift;
    logic rx_shift;

    slot_arbiter #(
        .node_id (node_id)
    ) arb (
        .clk     (clk),
        .rst     (rst),
        .bsy_in  (bsy_in),
        .tx_busy (tx_busy),
        .grant   (grant)
    );

    tx_fsm tx (
        .clk     (clk),
        .rst     (rst),
        .grant   (grant),
        .pndng   (pndng),
        .pop     (pop),
        .load    (tx_load),
        .shift   (tx_shift),
        .tx_busy (tx_busy)
    );

    // Parallel in, serial out
    shift_reg tx_sreg (
        .clk        (clk),
        .rst        (rst),
        .load       (tx_load),
        .shift      (tx_shift),
        .load_data  (d_pop),
        .serial_in  (1'b0),     // Drains to zero after a frame
        .data       (),
        .serial_out (bus_out)
    );

    rx_fsm #(
        .node_id (node_id)
    ) rx (
        .clk     (clk),
        .rst     (rst),
        .bsy_in  (bsy_in),
        .rx_data (d_push),
        .shift   (rx_shift),
        .push    (push)
    );

    // Serial in, parallel out
    shift_reg rx_sreg (
        .clk        (clk),
        .rst        (rst),
        .load       (1'b0),
        .shift      (rx_shift),
        .load_data  ('0),
        .serial_in  (bus_in),
        .data       (d_push),
        .serial_out ()
    );

    assign bus_oe  = tx_busy;   // Drive only during own frame
    assign bsy_out = tx_busy;

endmodule

// File: tb_bus_node.sv
`timescale 1ns/1ps

module tb_bus_node;

    localparam bus_node_pkg::addr_t node_id = 8'd2;
    localparam int pw = bus_node_pkg::pkt_width;
    // Rough test length of frames, transmit waits and a margin
    localparam int watchdog_cycles = 16 * (pw + 6) + 8 * (3 * pw + 8) + 300;

    logic clk;
    logic rst;
    logic pndng;
    bus_node_pkg::pkt_t d_pop;
    logic pop;
    logic push;
    bus_node_pkg::pkt_t d_push;
    logic bus_in;
    logic bsy_in;
    logic bus_out;
    logic bus_oe;
    logic bsy_out;

    bus_node_pkg::pkt_t fifo_q[$];   // FIFO model contents
    logic pop_seen;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int frames_sent;
    int push_count;

    // Reference model state kept by the compare process
    int model_slot;
    int tx_left;
    int tx_idx;
    bus_node_pkg::pkt_t tx_pkt;
    int rx_cnt;
    logic rx_pending;
    bus_node_pkg::pkt_t rx_word;

    bus_node #(.node_id(node_id)) bus_node_i (
        .clk     (clk),
        .rst     (rst),
        .pndng   (pndng),
        .d_pop   (d_pop),
        .pop     (pop),
        .push    (push),
        .d_push  (d_push),
        .bus_in  (bus_in),
        .bsy_in  (bsy_in),
        .bus_out (bus_out),
        .bus_oe  (bus_oe),
        .bsy_out (bsy_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Slot moves only on cycles with nobody on the bus
    function automatic int next_slot(int slot, logic ext_busy, logic own_busy);
        if (ext_busy || own_busy)
            return slot;
        return (slot + 1) % bus_node_pkg::num_nodes;
    endfunction

    function automatic logic accepted(bus_node_pkg::pkt_t pkt);
        bus_node_pkg::addr_t dest;
        dest = pkt[pw-1:pw-8];
        return (dest == node_id) || (dest == 8'hff);
    endfunction

    // Bit idx of the serial stream with MSB first
    function automatic logic stream_bit(bus_node_pkg::pkt_t pkt, int idx);
        return pkt[pw-1-idx];
    endfunction

    function automatic bus_node_pkg::pkt_t make_pkt(bus_node_pkg::addr_t dest);
        bus_node_pkg::pkt_t pkt;
        pkt = bus_node_pkg::pkt_t'($urandom());
        pkt[pw-1:pw-8] = dest;
        return pkt;
    endfunction

    // FIFO head driven one edge after a pop
    always @(posedge clk) begin
        if (pop_seen) begin
            void'(fifo_q.pop_front());
            pop_seen = 1'b0;
        end
        pndng <= (fifo_q.size() > 0);
        d_pop <= (fifo_q.size() > 0) ? fifo_q[0] : '0;
    end

    // Compare process samples mid-cycle
    always @(negedge clk) begin
        logic busy;
        logic exp_pop;
        logic exp_push;
        if (rst) begin
            busy = (tx_left > 0);
            exp_pop = !busy && !bsy_in && pndng &&
                      (model_slot == int'(node_id) % bus_node_pkg::num_nodes);
            exp_push = rx_pending && accepted(rx_word);
            checks = checks + 1;
            assert (pop == exp_pop) else begin
                $display("[FAIL] %0t: pop %b, expected %b", $time, pop, exp_pop);
                errors++;
            end
            assert (!(pop && bsy_in)) else begin
                $display("[FAIL] %0t: pop while bus busy", $time);
                errors++;
            end
            assert (bsy_out == busy && bus_oe == busy) else begin
                $display("[FAIL] %0t: bsy_out %b bus_oe %b, expected %b",
                         $time, bsy_out, bus_oe, busy);
                errors++;
            end
            if (busy) begin
                assert (bus_out == stream_bit(tx_pkt, tx_idx)) else begin
                    $display("[FAIL] %0t: bus_out bit %0d wrong", $time, tx_idx);
                    errors++;
                end
            end
            assert (push == exp_push) else begin
                $display("[FAIL] %0t: push %b, expected %b", $time, push, exp_push);
                errors++;
            end
            if (exp_push) begin
                assert (d_push == rx_word) else begin
                    $display("[FAIL] %0t: d_push %h, expected %h", $time, d_push, rx_word);
                    errors++;
                end
            end
            if (push)
                push_count++;
            // Advance the models
            model_slot = next_slot(model_slot, bsy_in, busy);
            if (busy) begin
                tx_idx++;
                tx_left--;
                if (tx_left == 0)
                    frames_sent++;
            end
            if (exp_pop) begin
                tx_pkt = d_pop;
                tx_left = pw;
                tx_idx = 0;
            end
            if (pop)
                pop_seen = 1'b1;
            if (rx_pending) begin
                rx_pending = 1'b0;   // Check cycle ignores the bus
                rx_cnt = 0;
            end else if (bsy_in) begin
                rx_word = {rx_word[pw-2:0], bus_in};
                rx_cnt++;
                if (rx_cnt == pw) begin
                    rx_pending = 1'b1;
                    rx_cnt = 0;
                end
            end else begin
                rx_cnt = 0;   // Short frame thrown away
            end
        end
    end

    // Plays another node on the bus for len cycles
    task automatic send_frame(bus_node_pkg::pkt_t pkt, int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            bsy_in <= 1'b1;
            bus_in <= pkt[pw-1-i];
        end
        @(posedge clk);
        bsy_in <= 1'b0;
        bus_in <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic wait_tx_done(int target);
        int cyc;
        cyc = 0;
        while (frames_sent < target && cyc < 8 * pw) begin
            @(posedge clk);
            cyc++;
        end
        if (frames_sent < target) begin
            $display("Transmit frame never completed at %0t", $time);
            errors++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(string name, int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        int err0;
        int pushes0;
        int exp_pushes;
        bus_node_pkg::pkt_t pkt;
        bus_node_pkg::addr_t dest;
        void'($urandom(32'h3b00));
        rst = 1'b0;
        pndng = 1'b0;
        d_pop = '0;
        bus_in = 1'b0;
        bsy_in = 1'b0;
        pop_seen = 1'b0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        frames_sent = 0;
        push_count = 0;
        model_slot = 0;
        tx_left = 0;
        tx_idx = 0;
        tx_pkt = '0;
        rx_cnt = 0;
        rx_pending = 1'b0;
        rx_word = '0;

        repeat (4) @(posedge clk);
        err0 = errors;
        assert (!pop && !push && !bus_oe && !bsy_out && !bus_out && d_push == '0) else begin
            $display("[FAIL] %0t: outputs not idle in reset", $time);
            errors++;
        end
        rst <= 1'b1;
        @(negedge clk);
        assert (!pop && !push && !bus_oe && !bsy_out && !bus_out && d_push == '0) else begin
            $display("[FAIL] %0t: outputs not idle after reset", $time);
            errors++;
        end
        end_test("reset state", err0);

        // Transmit on slot with an idle bus
        err0 = errors;
        for (int n = 0; n < 3; n++) begin
            @(negedge clk);
            fifo_q.push_back(bus_node_pkg::pkt_t'($urandom()));
            wait_tx_done(frames_sent + 1);
        end
        end_test("transmit on slot", err0);

        // Packet arrives while another node holds the bus
        err0 = errors;
        for (int n = 0; n < 3; n++) begin
            pkt = make_pkt(8'h07);
            fork
                send_frame(pkt, pw - 1 - n);   // Busy length off the slot period
                begin
                    repeat (2 + n) @(negedge clk);
                    fifo_q.push_back(bus_node_pkg::pkt_t'($urandom()));
                end
            join
            wait_tx_done(frames_sent + 1);
        end
        end_test("slot freeze", err0);

        err0 = errors;
        pushes0 = push_count;
        exp_pushes = 0;
        for (int n = 0; n < 9; n++) begin
            case (n % 3)
                0: dest = node_id;
                1: dest = 8'hff;
                default: begin
                    dest = bus_node_pkg::addr_t'($urandom());
                    if (dest == node_id || dest == 8'hff)
                        dest = 8'h05;
                end
            endcase
            pkt = make_pkt(dest);
            if (accepted(pkt))
                exp_pushes++;
            send_frame(pkt, pw);
        end
        assert (push_count - pushes0 == exp_pushes) else begin
            $display("[FAIL] %0t: %0d pushes, expected %0d", $time,
                     push_count - pushes0, exp_pushes);
            errors++;
        end
        end_test("address filtering", err0);

        err0 = errors;
        pushes0 = push_count;
        send_frame(make_pkt(node_id), 7);   // Cut short
        send_frame(make_pkt(node_id), pw);
        assert (push_count - pushes0 == 1) else begin
            $display("[FAIL] %0t: %0d pushes after truncated frame, expected 1",
                     $time, push_count - pushes0);
            errors++;
        end
        end_test("truncated frame", err0);

        $display("Tests: %0d run, %0d failed, %0d cycles checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: vlog.f
bus_node_pkg.sv
shift_reg.sv
slot_arbiter.sv
tx_fsm.sv
rx_fsm.sv
bus_node.sv
tb_bus_node.sv

// File: Makefile
# Verilator build for the bus node testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FLIST     ?= vlog.f
TOP       ?= tb_bus_node
RTL_TOP   ?= bus_node
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Lint the RTL on its own, then the whole testbench
lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		bus_node_pkg.sv shift_reg.sv slot_arbiter.sv tx_fsm.sv rx_fsm.sv bus_node.sv
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
